/* Makefile */
# Verilator simulation of the memory-mapped master translator

VERILATOR ?= verilator
TOP       ?= mm_translator_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

# build, run, then decide the result from the printed pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* include/mm_translator_params.svh */
`ifndef MM_TRANSLATOR_PARAMS_SVH
`define MM_TRANSLATOR_PARAMS_SVH

// ----------------------------------------------------------------------
// master side, word addressed
// ----------------------------------------------------------------------
`define AV_ADDRESS_W      32
`define AV_DATA_W         32
`define AV_BYTEENABLE_W   4
// burst length in words, largest burst is 8
`define AV_BURSTCOUNT_W   4

// log2 of bytes per word
`define BYTE_SHIFT        2

// ----------------------------------------------------------------------
// universal side, byte addressed
// ----------------------------------------------------------------------
`define UAV_ADDRESS_W     (`AV_ADDRESS_W + `BYTE_SHIFT)
`define UAV_BURSTCOUNT_W  (`AV_BURSTCOUNT_W + `BYTE_SHIFT)

`define RESPONSE_W        2

`endif

/* rtl/address_burst_mapper.sv */
`default_nettype none

`include "mm_translator_params.svh"

module address_burst_mapper (
   input  logic                           clk,
   input  logic                           reset,
   input  mm_translator_pkg::av_cmd_t     av_cmd,
   input  mm_translator_pkg::beat_state_t beat,
   output mm_translator_pkg::uav_cmd_t    uav_cmd
);

   // one word in byte units, sized to the byte address
   localparam logic [`UAV_ADDRESS_W-1:0] bytes_per_word =
      {{(`UAV_ADDRESS_W - `BYTE_SHIFT - 1){1'b0}}, 1'b1, {`BYTE_SHIFT{1'b0}}};

   logic [`UAV_ADDRESS_W-1:0]    start_address;
   logic [`UAV_BURSTCOUNT_W-1:0] start_count;
   logic [`UAV_BURSTCOUNT_W-1:0] remaining_count;
   logic [`UAV_ADDRESS_W-1:0]    beat_address;
   logic [`UAV_ADDRESS_W-1:0]    current_address;

   // ----------------------------------------------------------------------
   // word to byte conversion
   // ----------------------------------------------------------------------
   assign start_address   = {av_cmd.address, {`BYTE_SHIFT{1'b0}}};
   assign start_count     = {av_cmd.burstcount, {`BYTE_SHIFT{1'b0}}};
   assign remaining_count = {beat.beats_left, {`BYTE_SHIFT{1'b0}}};

   // first beat takes the master address, later beats the running one
   assign current_address = beat.begin_burst ? start_address : beat_address;

   // ----------------------------------------------------------------------
   // beat address register
   // ----------------------------------------------------------------------

   // moves one word ahead after every accepted write beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat_address <= '0;
      end else if (beat.beat_done) begin
         beat_address <= current_address + bytes_per_word;
      end
   end

   // ----------------------------------------------------------------------
   // universal command
   // ----------------------------------------------------------------------
   always_comb begin
      uav_cmd.write       = av_cmd.write;
      uav_cmd.read        = av_cmd.read;
      uav_cmd.address     = current_address;
      uav_cmd.byteenable  = av_cmd.byteenable;
      uav_cmd.writedata   = av_cmd.writedata;
      uav_cmd.lock        = av_cmd.lock;
      uav_cmd.debugaccess = av_cmd.debugaccess;

      // count of bytes still to go, the current beat included
      if (beat.begin_burst) begin
         uav_cmd.burstcount = start_count;
      end else begin
         uav_cmd.burstcount = remaining_count;
      end
   end

endmodule

`default_nettype wire

/* rtl/beat_sequencer.sv */
`default_nettype none

`include "mm_translator_params.svh"

module beat_sequencer (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           write,
   input  logic                           read,
   input  logic [`AV_BURSTCOUNT_W-1:0]    burstcount,
   input  logic                           waitrequest,
   output mm_translator_pkg::beat_state_t beat
);

   // a beat of the current write burst has been put on the bus
   logic                        beat_issued;
   // that beat was the first one and the slave has not taken it yet
   logic                        first_stalled;
   logic [`AV_BURSTCOUNT_W-1:0] beats_left;

   logic begin_burst;
   logic beat_accepted;
   logic last_beat;

   // ----------------------------------------------------------------------
   // burst start and beat acceptance
   // ----------------------------------------------------------------------

   // every read is its own burst start
   // a write starts a burst only if nothing of its burst is out yet,
   // or if the first beat is still waiting on the slave
   assign begin_burst = read | (write & (~beat_issued | first_stalled));

   assign beat_accepted = write & ~waitrequest;

   // at a start the master count decides, later the running count
   assign last_beat = begin_burst ? (burstcount <= `AV_BURSTCOUNT_W'(1))
                                  : (beats_left == `AV_BURSTCOUNT_W'(1));

   // ----------------------------------------------------------------------
   // burst state
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat_issued   <= 1'b0;
         first_stalled <= 1'b0;
         beats_left    <= '0;
      end else if (read) begin
         // a read closes any write burst state
         beat_issued   <= 1'b0;
         first_stalled <= 1'b0;
      end else if (write) begin
         if (waitrequest) begin
            // stalled beat keeps its flags, except the first one is marked
            if (begin_burst) begin
               beat_issued   <= 1'b1;
               first_stalled <= 1'b1;
            end
         end else begin
            first_stalled <= 1'b0;
            beat_issued   <= ~last_beat;
            if (begin_burst) begin
               beats_left <= burstcount - 1'b1;
            end else begin
               beats_left <= beats_left - 1'b1;
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // report to the mapper
   // ----------------------------------------------------------------------
   always_comb begin
      beat.begin_burst = begin_burst;
      beat.beat_done   = beat_accepted;
      beat.beats_left  = beats_left;
   end

endmodule

`default_nettype wire

/* rtl/mm_translator_pkg.sv */
`default_nettype none

`include "mm_translator_params.svh"

package mm_translator_pkg;

   // command as issued by the word-addressed master
   typedef struct packed {
      logic                        write;
      logic                        read;
      logic [`AV_ADDRESS_W-1:0]    address;
      logic [`AV_BYTEENABLE_W-1:0] byteenable;
      logic [`AV_BURSTCOUNT_W-1:0] burstcount;
      logic [`AV_DATA_W-1:0]       writedata;
      logic                        lock;
      logic                        debugaccess;
   } av_cmd_t;

   // same command with address and count in bytes
   typedef struct packed {
      logic                         write;
      logic                         read;
      logic [`UAV_ADDRESS_W-1:0]    address;
      logic [`AV_BYTEENABLE_W-1:0]  byteenable;
      logic [`UAV_BURSTCOUNT_W-1:0] burstcount;
      logic [`AV_DATA_W-1:0]        writedata;
      logic                         lock;
      logic                         debugaccess;
   } uav_cmd_t;

   typedef struct packed {
      logic [`AV_DATA_W-1:0]  readdata;
      logic                   readdatavalid;
      logic [`RESPONSE_W-1:0] response;
   } rsp_t;

   // sequencer to mapper
   typedef struct packed {
      logic                        begin_burst;
      logic                        beat_done;
      logic [`AV_BURSTCOUNT_W-1:0] beats_left;
   } beat_state_t;

endpackage

`default_nettype wire

/* rtl/mm_translator_top.sv */
`default_nettype none

module mm_translator_top (
   input  logic                        clk,
   input  logic                        reset,

   // word-addressed master
   input  mm_translator_pkg::av_cmd_t  av_cmd,
   output logic                        av_waitrequest,
   output mm_translator_pkg::rsp_t     av_rsp,

   // byte-addressed universal port
   output mm_translator_pkg::uav_cmd_t uav_cmd,
   input  logic                        uav_waitrequest,
   input  mm_translator_pkg::rsp_t     uav_rsp
);

   mm_translator_pkg::beat_state_t beat;

   // ----------------------------------------------------------------------
   // passthrough paths
   // ----------------------------------------------------------------------

   // back-pressure comes only from the slave
   assign av_waitrequest = uav_waitrequest;

   // read data, valid and response code go back untouched
   assign av_rsp = uav_rsp;

   // ----------------------------------------------------------------------
   // burst tracking
   // ----------------------------------------------------------------------

   // watches the translated command as the slave sees it
   beat_sequencer beat_sequencer_inst (
      .clk         (clk),
      .reset       (reset),
      .write       (uav_cmd.write),
      .read        (uav_cmd.read),
      .burstcount  (av_cmd.burstcount),
      .waitrequest (uav_waitrequest),
      .beat        (beat)
   );

   // ----------------------------------------------------------------------
   // address and count translation
   // ----------------------------------------------------------------------
   address_burst_mapper address_burst_mapper_inst (
      .clk     (clk),
      .reset   (reset),
      .av_cmd  (av_cmd),
      .beat    (beat),
      .uav_cmd (uav_cmd)
   );

endmodule

`default_nettype wire

/* src.f */
+incdir+include
rtl/mm_translator_pkg.sv
rtl/beat_sequencer.sv
rtl/address_burst_mapper.sv
rtl/mm_translator_top.sv
verif/mm_translator_properties.sv
verif/mm_translator_tb.sv

/* verif/mm_translator_properties.sv */
`default_nettype none

`include "mm_translator_params.svh"

module mm_translator_properties (
   input logic                        clk,
   input logic                        reset,
   input mm_translator_pkg::uav_cmd_t uav_cmd,
   input logic                        uav_waitrequest,
   input logic                        av_waitrequest
);

   // a presented command stays put until the slave takes it
   property stalled_cmd_holds;
      @(posedge clk) disable iff (reset)
         (uav_waitrequest && (uav_cmd.write || uav_cmd.read)) |=> (uav_cmd == $past(uav_cmd));
   endproperty

   assert property (stalled_cmd_holds)
      else $error("uav_cmd changed while uav_waitrequest was high");

   assert property (@(posedge clk) av_waitrequest == uav_waitrequest)
      else $error("av_waitrequest differs from uav_waitrequest");

   // byte address and byte count are whole words
   assert property (@(posedge clk) disable iff (reset)
      (uav_cmd.address[`BYTE_SHIFT-1:0] == '0) && (uav_cmd.burstcount[`BYTE_SHIFT-1:0] == '0))
      else $error("uav address or burstcount not word aligned");

endmodule

bind mm_translator_top mm_translator_properties mm_translator_properties_inst (
   .clk             (clk),
   .reset           (reset),
   .uav_cmd         (uav_cmd),
   .uav_waitrequest (uav_waitrequest),
   .av_waitrequest  (av_waitrequest)
);

`default_nettype wire

/* verif/mm_translator_tb.sv */
`default_nettype none

`include "mm_translator_params.svh"

module mm_translator_tb;

   typedef logic [`UAV_ADDRESS_W-1:0]    byte_addr_t;
   typedef logic [`UAV_BURSTCOUNT_W-1:0] byte_count_t;
   typedef logic [`AV_BURSTCOUNT_W-1:0]  word_count_t;
   typedef logic [`AV_BYTEENABLE_W-1:0]  be_t;
   typedef logic [`RESPONSE_W-1:0]       resp_code_t;
   typedef logic [127:0]                 check_word_t;

   localparam int period = 4;
   localparam int num_cmds = 300;
   localparam int seed = 62209;
   // two extra commands cover the reset recovery bursts
   localparam int watchdog_time = (num_cmds + 2) * 8 * 8 * period;

   logic clk = 1'b0;
   logic reset;
   mm_translator_pkg::av_cmd_t  av_cmd;
   logic                        av_waitrequest;
   mm_translator_pkg::rsp_t     av_rsp;
   mm_translator_pkg::uav_cmd_t uav_cmd;
   logic                        uav_waitrequest;
   mm_translator_pkg::rsp_t     uav_rsp;

   int issued_reads = 0;
   int accepted_reads = 0;
   int words_requested = 0;
   int words_returned = 0;

   always #(period / 2) clk = ~clk;

   mm_translator_top mm_translator_top_inst (
      .clk             (clk),
      .reset           (reset),
      .av_cmd          (av_cmd),
      .av_waitrequest  (av_waitrequest),
      .av_rsp          (av_rsp),
      .uav_cmd         (uav_cmd),
      .uav_waitrequest (uav_waitrequest),
      .uav_rsp         (uav_rsp)
   );

   // ----------------------------------------------------------------------
   // checking and reference model
   // ----------------------------------------------------------------------
   task automatic check_value(input string name, input check_word_t actual,
                              input check_word_t expected);
      if (actual !== expected) begin
         $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   // beat k of an n-word command as the byte-addressed slave must see it
   function automatic mm_translator_pkg::uav_cmd_t expected_beat(
      input mm_translator_pkg::av_cmd_t cmd, input int k, input int n);
      mm_translator_pkg::uav_cmd_t exp;
      exp.write       = cmd.write;
      exp.read        = cmd.read;
      exp.address     = byte_addr_t'(cmd.address) * byte_addr_t'(4) + byte_addr_t'(4 * k);
      exp.byteenable  = cmd.byteenable;
      exp.burstcount  = byte_count_t'(4 * (n - k));
      exp.writedata   = cmd.writedata;
      exp.lock        = cmd.lock;
      exp.debugaccess = cmd.debugaccess;
      return exp;
   endfunction

   // ----------------------------------------------------------------------
   // random master
   // ----------------------------------------------------------------------
   function automatic mm_translator_pkg::av_cmd_t random_cmd(input logic write, input logic read,
                                                             input logic [31:0] base, input int n);
      mm_translator_pkg::av_cmd_t c;
      c.write       = write;
      c.read        = read;
      c.address     = base;
      c.byteenable  = be_t'($urandom);
      c.burstcount  = word_count_t'(n);
      c.writedata   = $urandom;
      c.lock        = 1'($urandom);
      c.debugaccess = 1'($urandom);
      return c;
   endfunction

   // holds the command until the translator accepts it, then checks that beat
   task automatic present_beat(input mm_translator_pkg::av_cmd_t cmd,
                               input mm_translator_pkg::uav_cmd_t expected);
      logic accepted;
      accepted = 1'b0;
      av_cmd = cmd;
      while (!accepted) begin
         @(negedge clk);
         if (!av_waitrequest) begin
            accepted = 1'b1;
            check_value("uav_cmd", check_word_t'(uav_cmd), check_word_t'(expected));
         end
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_write_burst(input logic [31:0] base, input int n);
      mm_translator_pkg::av_cmd_t cmd;
      for (int k = 0; k < n; k++) begin
         cmd = random_cmd(1'b1, 1'b0, base, n);
         present_beat(cmd, expected_beat(cmd, k, n));
      end
   endtask

   task automatic run_read(input logic [31:0] base, input int n);
      mm_translator_pkg::av_cmd_t cmd;
      cmd = random_cmd(1'b0, 1'b1, base, n);
      issued_reads++;
      present_beat(cmd, expected_beat(cmd, 0, n));
   endtask

   // reset in the middle of an 8-word burst, then a fresh burst
   task automatic reset_recovery();
      mm_translator_pkg::av_cmd_t cmd;
      logic [31:0] base;
      base = $urandom;
      for (int k = 0; k < 3; k++) begin
         cmd = random_cmd(1'b1, 1'b0, base, 8);
         present_beat(cmd, expected_beat(cmd, k, 8));
      end
      av_cmd.write = 1'b0;
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      run_write_burst($urandom, 4);
   endtask

   initial begin
      int kind;
      void'($urandom(seed));
      av_cmd = '0;
      reset = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < num_cmds; i++) begin
         kind = $urandom % 3;
         if (kind == 0) begin
            run_write_burst($urandom, 1);
         end else if (kind == 1) begin
            run_write_burst($urandom, 1 + $urandom % 8);
         end else begin
            run_read($urandom, 1 + $urandom % 8);
         end
         av_cmd.write = 1'b0;
         av_cmd.read  = 1'b0;
         repeat ($urandom % 3) begin
            @(posedge clk);
            #1;
         end
      end
      reset_recovery();
      av_cmd.write = 1'b0;
      // let the outstanding read data drain
      while (words_returned != words_requested) @(posedge clk);
      check_value("accepted_reads", check_word_t'(accepted_reads), check_word_t'(issued_reads));
      $display("Testbench passed");
      $finish;
   end

   // ----------------------------------------------------------------------
   // random slave that stalls about a third of the cycles
   // ----------------------------------------------------------------------
   initial begin
      logic in_reset;
      int countdown;
      countdown = 0;
      uav_waitrequest = 1'b0;
      uav_rsp = '0;
      forever begin
         @(posedge clk);
         in_reset = reset;
         #1;
         uav_rsp = '0;
         if (in_reset) begin
            uav_waitrequest = 1'b0;
            words_returned = words_requested;
            countdown = 0;
         end else begin
            uav_waitrequest = ($urandom % 3 == 0);
            if (words_returned != words_requested) begin
               if (countdown == 0) begin
                  countdown = 1 + $urandom % 4;
               end
               countdown--;
               if (countdown == 0) begin
                  uav_rsp.readdata      = $urandom;
                  uav_rsp.readdatavalid = 1'b1;
                  uav_rsp.response      = resp_code_t'($urandom);
                  words_returned++;
               end
            end
         end
      end
   end

   // passthrough checks and read bookkeeping at mid cycle
   always @(negedge clk) begin
      if (!reset) begin
         check_value("av_waitrequest", check_word_t'(av_waitrequest),
                     check_word_t'(uav_waitrequest));
         check_value("av_rsp", check_word_t'(av_rsp), check_word_t'(uav_rsp));
         if (uav_cmd.read && !uav_waitrequest) begin
            accepted_reads++;
            words_requested += int'(av_cmd.burstcount);
         end
      end
   end

   initial begin
      #(watchdog_time);
      $display("timeout: the tests did not finish in the time allowed");
      $display("Testbench failed");
      $fatal(1);
   end

endmodule

`default_nettype wire
